// ==== Makefile ====
# Verilator flow for the iNES loader

VERILATOR ?= verilator
FILELIST  ?= all.f
TB_TOP    ?= rom_loader_tb
RTL_TOP   ?= rom_loader
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
FAIL_MSG  := *** FAILED ***
PASS_MSG  := *** PASSED ***

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)

sim: build
	./$(BUILD_DIR)/V$(TB_TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -qF '$(PASS_MSG)' $(LOG) || (echo "simulation did not complete"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== all.f ====
+incdir+include
hw/ines_pkg.sv
hw/loader_pkg.sv
hw/ines_header_parser.sv
hw/load_sequencer.sv
hw/mem_write_bridge.sv
hw/rom_loader.sv
testbench/rom_loader_tb.sv

// ==== hw/ines_header_parser.sv ====
// Collects the 16 iNES header bytes, validates them and decodes the mapper-flags word
// Result is registered and held until the next reset
`timescale 1ns/1ps
`default_nettype none

module ines_header_parser (
  input  wire                       clk,
  input  wire                       reset,
  input  loader_pkg::byte_t         in_byte,
  input  wire                       take,         // Header byte transferred
  output ines_pkg::image_layout_t   layout,
  output ines_pkg::mapper_flags_t   mapper_flags,
  output logic                      flags_valid,
  output logic                      hdr_ok,
  output logic                      hdr_bad
);

  loader_pkg::byte_t hdr [ines_pkg::HEADER_BYTES]; // Raw header bytes
  logic [3:0] cnt;      // Next header slot
  logic       full;     // Last byte landed on the previous edge
  logic       is_nes20;
  logic       dirty;
  logic       valid;
  loader_pkg::byte_t extra; // OR of bytes 8..15
  ines_pkg::mapper_flags_t flags_d;

  always_ff @(posedge clk) begin
    if (take) hdr[cnt] <= in_byte; // Storage only, no reset
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      cnt         <= '0;
      full        <= 1'b0;
      flags_valid <= 1'b0;
      hdr_ok      <= 1'b0;
      hdr_bad     <= 1'b0;
    end else begin
      full    <= 1'b0;
      hdr_ok  <= 1'b0; // Single-cycle pulses
      hdr_bad <= 1'b0;
      if (take) begin
        cnt  <= cnt + 4'd1;
        full <= (cnt == 4'(ines_pkg::HEADER_BYTES - 1));
      end
      if (full) begin
        flags_valid <= 1'b1;
        hdr_ok      <= valid;
        hdr_bad     <= !valid;
      end
    end
  end

  // Decoded values, captured once with the pulse
  always_ff @(posedge clk) begin
    if (full) begin
      mapper_flags     <= flags_d;
      layout.prg_pages <= hdr[4];
      layout.chr_pages <= hdr[5];
    end
  end

  always_comb begin
    extra = '0;
    for (int i = 8; i < ines_pkg::HEADER_BYTES; i++) begin
      extra = extra | hdr[i];
    end
    is_nes20 = (hdr[7][3:2] == 2'b10);      // NES 2.0 signature
    dirty    = !is_nes20 && (extra != '0);   // Junk in the tail of a 1.0 header
    // Signature must match, trainers unsupported
    valid = ({hdr[0], hdr[1], hdr[2], hdr[3]} == ines_pkg::INES_MAGIC) && !hdr[6][2];

    flags_d             = '0;
    flags_d.four_screen = hdr[6][3];
    flags_d.has_chr_ram = (hdr[5] == 8'd0);
    flags_d.mirroring   = hdr[6][0];
    flags_d.chr_size    = ines_pkg::size_code(hdr[5]);
    flags_d.prg_size    = ines_pkg::size_code(hdr[4]);
    flags_d.mapper      = {dirty ? 4'h0 : hdr[7][7:4], hdr[6][7:4]}; // Upper nibble only if trusted
  end

  // Flags frozen once published
  assert property (@(posedge clk) disable iff (reset)
    flags_valid && $past(flags_valid) |-> $stable(mapper_flags))
    else $error("mapper_flags changed after flags_valid");

endmodule

`default_nettype wire

// ==== hw/ines_pkg.sv ====
// iNES file format: header layout constants, page sizes and the packed mapper-flags word
// Used by the header parser and the load sequencer
`default_nettype none

package ines_pkg;

  localparam int HEADER_BYTES = 16;                   // Fixed iNES header length
  localparam logic [31:0] INES_MAGIC = 32'h4E45_531A; // "NES" then 0x1A, byte 0 in the MSBs
  localparam int PRG_PAGE_SHIFT = 14;                 // 16 KiB PRG pages
  localparam int CHR_PAGE_SHIFT = 13;                 // 8 KiB CHR pages

  typedef logic [7:0] page_count_t; // Header bytes 4 and 5
  typedef logic [2:0] size_code_t;  // Rounded log2 of a page count

  // Flags word handed to the console core
  typedef struct packed {
    logic [14:0] pad;          // Always zero
    logic        four_screen;  // Byte 6 bit 3
    logic        has_chr_ram;  // No CHR pages in the image
    logic        mirroring;    // Byte 6 bit 0
    size_code_t  chr_size;
    size_code_t  prg_size;
    logic [7:0]  mapper;
  } mapper_flags_t;

  typedef struct packed {
    page_count_t prg_pages;
    page_count_t chr_pages;
  } image_layout_t;

  // Smallest power of two that holds the count, 7 above 64
  function automatic size_code_t size_code(page_count_t n);
    if (n <= 8'd1) return 3'd0;
    else if (n <= 8'd2) return 3'd1;
    else if (n <= 8'd4) return 3'd2;
    else if (n <= 8'd8) return 3'd3;
    else if (n <= 8'd16) return 3'd4;
    else if (n <= 8'd32) return 3'd5;
    else if (n <= 8'd64) return 3'd6;
    else return 3'd7;
  endfunction

endpackage

`default_nettype wire

// ==== hw/load_sequencer.sv ====
// Steers the header bytes to the parser and the PRG and CHR payload to the write bridge
// Counts payload bytes and generates the cartridge addresses
`timescale 1ns/1ps
`default_nettype none

module load_sequencer (
  input  wire                       clk,
  input  wire                       reset,
  input  loader_pkg::byte_t         in_byte,
  input  wire                       in_valid,
  output logic                      in_ready,
  output logic                      hdr_take,
  input  ines_pkg::image_layout_t   layout,
  input  wire                       hdr_ok,
  input  wire                       hdr_bad,
  output loader_pkg::mem_write_t    wr,
  output logic                      wr_push,
  input  wire                       wr_busy,
  output logic                      done,
  output logic                      error
);

  typedef enum logic [2:0] {HEADER, CHECK, PRG, CHR, FINISH, DONE, FAIL} state_t;

  state_t                 state;
  logic [3:0]             hdr_cnt;   // Header bytes seen
  loader_pkg::mem_addr_t  wr_addr;   // Address of the next payload byte
  loader_pkg::mem_addr_t  remain;    // Bytes left in the current region
  loader_pkg::mem_addr_t  prg_bytes;
  loader_pkg::mem_addr_t  chr_bytes;
  logic                   accept;    // Payload byte transfer

  assign prg_bytes = loader_pkg::mem_addr_t'(layout.prg_pages) << ines_pkg::PRG_PAGE_SHIFT;
  assign chr_bytes = loader_pkg::mem_addr_t'(layout.chr_pages) << ines_pkg::CHR_PAGE_SHIFT;

  always_comb begin
    case (state)
      HEADER, DONE, FAIL: in_ready = 1'b1;          // Trailing bytes are dropped
      PRG, CHR:           in_ready = !wr_busy;      // One byte in flight at most
      default:            in_ready = done || error; // Ready again as soon as the load ends
    endcase
  end

  assign hdr_take = (state == HEADER) && in_valid;
  assign accept   = (state == PRG || state == CHR) && in_valid && in_ready;
  assign done     = (state == DONE) || (state == FINISH && !wr_busy);
  assign error    = (state == FAIL) || (state == CHECK && hdr_bad);

  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= HEADER;
      hdr_cnt <= '0;
      wr_addr <= '0;
      remain  <= '0;
      wr_push <= 1'b0;
    end else begin
      wr_push <= 1'b0;
      case (state)
        HEADER: if (hdr_take) begin
          hdr_cnt <= hdr_cnt + 4'd1;
          if (hdr_cnt == 4'(ines_pkg::HEADER_BYTES - 1)) state <= CHECK;
        end
        CHECK: if (hdr_bad) begin
          state <= FAIL;
        end else if (hdr_ok) begin
          if (layout.prg_pages != '0) begin
            state   <= PRG;
            remain  <= prg_bytes;
            wr_addr <= '0;
          end else if (layout.chr_pages != '0) begin // Empty PRG goes straight to CHR
            state   <= CHR;
            remain  <= chr_bytes;
            wr_addr <= loader_pkg::CHR_BASE;
          end else begin
            state <= FINISH;
          end
        end
        PRG, CHR: if (accept) begin
          wr.addr <= wr_addr;
          wr.data <= in_byte;
          wr_push <= 1'b1;
          wr_addr <= wr_addr + 1'b1;
          remain  <= remain - 1'b1;
          if (remain == loader_pkg::mem_addr_t'(1)) begin // Last byte of the region
            if (state == PRG && layout.chr_pages != '0) begin
              state   <= CHR;
              remain  <= chr_bytes;
              wr_addr <= loader_pkg::CHR_BASE;
            end else begin
              state <= FINISH;
            end
          end
        end
        FINISH: if (!wr_busy) state <= DONE; // Wait for the last write to drain
        default: ;
      endcase
    end
  end

  // No write once done or error is showing
  assert property (@(posedge clk) disable iff (reset) (done || error) |-> !wr_push)
    else $error("write pushed after load ended");

endmodule

`default_nettype wire

// ==== hw/loader_pkg.sv ====
// Cartridge memory map and the byte write bus between sequencer, bridge and memory
// Shared by every loader module
`default_nettype none

package loader_pkg;

  localparam int ADDR_W = 22; // 4 MiB cartridge space

  typedef logic [7:0] byte_t;
  typedef logic [ADDR_W-1:0] mem_addr_t;

  // PRG lives from 0 up, CHR from the upper half
  localparam mem_addr_t CHR_BASE = 22'h20_0000;

  // One byte write, address and data move together
  typedef struct packed {
    mem_addr_t addr;
    byte_t     data;
  } mem_write_t;

endpackage

`default_nettype wire

// ==== hw/mem_write_bridge.sv ====
// Holds one byte write and runs the four-phase req/ack handshake to cartridge memory
// Busy covers the push cycle so the sequencer never overruns the holding register
`timescale 1ns/1ps
`default_nettype none

module mem_write_bridge (
  input  wire                      clk,
  input  wire                      reset,
  input  loader_pkg::mem_write_t   wr,
  input  wire                      wr_push,
  output logic                     wr_busy,
  output loader_pkg::mem_write_t   mem_wr,
  output logic                     mem_req,
  input  wire                      mem_ack
);

  typedef enum logic [1:0] {IDLE, REQ, WAIT_LOW} state_t;

  state_t state;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE:     if (wr_push) state <= REQ;
        REQ:      if (mem_ack) state <= WAIT_LOW;  // Drop req the cycle after ack
        WAIT_LOW: if (!mem_ack) state <= IDLE;     // Return to zero
        default:  state <= IDLE;
      endcase
    end
  end

  // Holding register, stable for the whole handshake
  always_ff @(posedge clk) begin
    if (state == IDLE && wr_push) mem_wr <= wr;
  end

  assign mem_req = (state == REQ);
  // Free again as soon as ack has fallen
  assign wr_busy = wr_push || (state == REQ) || (state == WAIT_LOW && mem_ack);

  // Request held until the memory answers
  assert property (@(posedge clk) disable iff (reset) (state == REQ && !mem_ack) |=> mem_req)
    else $error("mem_req dropped before mem_ack");

  // Sequencer respects busy, pushes land only in IDLE
  assert property (@(posedge clk) disable iff (reset) wr_push |-> (state == IDLE))
    else $error("wr_push while bridge busy");

endmodule

`default_nettype wire

// ==== hw/rom_loader.sv ====
// Cartridge-image loader top: header parser, load sequencer and memory write bridge in a chain
// Streams an iNES file in and writes PRG and CHR pages to cartridge memory
`timescale 1ns/1ps
`default_nettype none

module rom_loader (
  input  wire                      clk,
  input  wire                      reset,
  input  loader_pkg::byte_t        in_byte,
  input  wire                      in_valid,
  output logic                     in_ready,
  output loader_pkg::mem_write_t   mem_wr,
  output logic                     mem_req,
  input  wire                      mem_ack,
  output ines_pkg::mapper_flags_t  mapper_flags,
  output logic                     flags_valid,
  output logic                     done,
  output logic                     error
);

  logic                     hdr_take;  // Header byte to parser
  ines_pkg::image_layout_t  layout;    // Page counts from the header
  logic                     hdr_ok;
  logic                     hdr_bad;
  loader_pkg::mem_write_t   wr;        // Sequencer to bridge
  logic                     wr_push;
  logic                     wr_busy;

  ines_header_parser u_parser (
    .clk, .reset, .in_byte,
    .take(hdr_take),
    .layout, .mapper_flags, .flags_valid, .hdr_ok, .hdr_bad
  );

  load_sequencer u_seq (
    .clk, .reset, .in_byte, .in_valid, .in_ready, .hdr_take,
    .layout, .hdr_ok, .hdr_bad,
    .wr, .wr_push, .wr_busy, .done, .error
  );

  mem_write_bridge u_bridge (
    .clk, .reset, .wr, .wr_push, .wr_busy, .mem_wr, .mem_req, .mem_ack
  );

endmodule

`default_nettype wire

// ==== include/rom_loader_tb_cases.svh ====
// Header cases for the loader testbench, one row per image
// Included inside the testbench module, rows are applied in order
`ifndef ROM_LOADER_TB_CASES_SVH
`define ROM_LOADER_TB_CASES_SVH

localparam int NUM_CASES   = 8;
localparam int EXTRA_BYTES = 32; // Trailing bytes sent after a rejected header

// Header bytes with byte 0 in the MSBs, expected flags word, rejection expected
typedef struct packed {
  logic [127:0]            hdr;
  ines_pkg::mapper_flags_t flags;
  logic                    bad;
} case_row_t;

localparam case_row_t CASES [NUM_CASES] = '{
  // 2 PRG, 1 CHR, vertical mirroring, mapper 1
  {128'h4E45531A_02011100_00000000_00000000, 32'h0000_4101, 1'b0},
  // 1 PRG, CHR RAM, four-screen, mapper 0x24
  {128'h4E45531A_01004820_00000000_00000000, 32'h0001_8024, 1'b0},
  // Dirty 1.0 header, byte 12 nonzero
  {128'h4E45531A_01013050_00000000_44000000, 32'h0000_0003, 1'b0},
  {128'h4E45531A_01013058_00000000_44000000, 32'h0000_0053, 1'b0}, // Same tail, NES 2.0
  {128'h4E45531B_01010000_00000000_00000000, 32'h0000_0000, 1'b1}, // Bad signature
  {128'h4E45531A_02020400_00000000_00000000, 32'h0000_0900, 1'b1}, // Trainer present
  {128'h4E45531A_00020100_00000000_00000000, 32'h0000_4800, 1'b0}, // No PRG, CHR only
  // Largest image, 2 PRG plus 2 CHR
  {128'h4E45531A_0202A910_00000000_00000000, 32'h0001_491A, 1'b0}
};

`endif

// ==== testbench/rom_loader_tb.sv ====
// Testbench for the iNES loader that streams each table case into a slow memory model
// Random valid gaps and ack delays exercise the back-pressure path
`timescale 1ns/1ps
`default_nettype none

module rom_loader_tb;

  `include "rom_loader_tb_cases.svh"

  localparam int CLK_PERIOD = 10;
  localparam int PRG_PAGE   = 16384;     // Bytes in one PRG page
  localparam int CHR_PAGE   = 8192;      // Bytes in one CHR page
  localparam int CHR_START  = 'h20_0000; // Cartridge address of CHR byte 0

  logic                     clk;
  logic                     reset;
  loader_pkg::byte_t        in_byte;
  logic                     in_valid;
  logic                     in_ready;
  loader_pkg::mem_write_t   mem_wr;
  logic                     mem_req;
  logic                     mem_ack;
  ines_pkg::mapper_flags_t  mapper_flags;
  logic                     flags_valid;
  logic                     done;
  logic                     error;

  loader_pkg::byte_t written [loader_pkg::mem_addr_t]; // Memory contents by address
  int write_count;
  int dup_count;   // Writes that hit an address twice
  int error_count;
  int pass_count;
  int fail_count;

  rom_loader uut (
    .clk, .reset, .in_byte, .in_valid, .in_ready,
    .mem_wr, .mem_req, .mem_ack,
    .mapper_flags, .flags_valid, .done, .error
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic check(input logic [31:0] got, input logic [31:0] exp, input string msg);
    if (got !== exp) begin
      error_count++;
      $display("FAIL @ %0t: %s, got %0h expected %0h", $time, msg, got, exp);
    end
  endtask

  // Random idle cycles before holding valid until the DUT takes the byte
  task automatic send_byte(input loader_pkg::byte_t b);
    int gap;
    gap = $urandom_range(3, 0);
    repeat (gap) @(negedge clk);
    in_byte  = b;
    in_valid = 1'b1;
    #1;                        // in_ready settled after the falling edge
    while (!in_ready) begin
      @(negedge clk);
      #1;
    end
    @(negedge clk);            // Transfer on the rising edge in between
    in_valid = 1'b0;
  endtask

  task automatic apply_reset();
    @(negedge clk);
    reset    = 1'b1;
    in_valid = 1'b0;
    repeat (2) @(negedge clk);
    reset = 1'b0;
  endtask

  task automatic wait_for_end();
    do begin
      @(negedge clk);
      #1;
    end while (!done && !error);
  endtask

  task automatic run_case(input int c);
    case_row_t             row;
    int                    prg_len;
    int                    chr_len;
    int                    bad;
    int                    errs_before;
    loader_pkg::mem_addr_t a;
    loader_pkg::byte_t     exp_b;
    row         = CASES[c];
    errs_before = error_count;
    prg_len     = int'(row.hdr[95:88]) * PRG_PAGE; // Header byte 4
    chr_len     = int'(row.hdr[87:80]) * CHR_PAGE; // Header byte 5
    apply_reset();
    written.delete();
    write_count = 0;
    dup_count   = 0;
    #1;
    check(in_ready, 1, "in_ready after reset");
    check({mem_req, done, error, flags_valid}, 0, "outputs after reset");
    @(negedge clk);
    for (int i = 0; i < ines_pkg::HEADER_BYTES; i++) send_byte(row.hdr[127 - 8 * i -: 8]);
    if (row.bad) begin
      for (int k = 0; k < EXTRA_BYTES; k++) send_byte(8'(k ^ 8'h5A)); // Must be dropped
    end else begin
      for (int k = 0; k < prg_len + chr_len; k++) send_byte(8'((k * 7 + c) % 256));
    end
    wait_for_end();
    check(in_ready, 1, "in_ready once the load ended");
    repeat (4) @(negedge clk);
    #1;
    check(flags_valid, 1, "flags_valid");
    check(mapper_flags, row.flags, "mapper_flags");
    check(error, row.bad, "error");
    check(done, !row.bad, "done");
    check(write_count, row.bad ? 0 : prg_len + chr_len, "write count");
    check(dup_count, 0, "duplicate writes");
    bad = 0;
    if (!row.bad) begin
      for (int k = 0; k < prg_len + chr_len; k++) begin
        a = (k < prg_len) ? loader_pkg::mem_addr_t'(k)
                          : loader_pkg::mem_addr_t'(CHR_START + k - prg_len);
        exp_b = 8'((k * 7 + c) % 256);
        if (!written.exists(a) || written[a] !== exp_b) bad++;
      end
    end
    check(bad, 0, "payload bytes missing or wrong");
    if (error_count == errs_before) begin
      pass_count++;
      $display("case %0d passed", c);
    end else begin
      fail_count++;
      $display("case %0d failed", c);
    end
  endtask

  // Upper bound on streamed bytes over every case
  function automatic longint total_bytes();
    longint sum;
    sum = 0;
    for (int c = 0; c < NUM_CASES; c++) begin
      sum += ines_pkg::HEADER_BYTES + EXTRA_BYTES;
      sum += longint'(CASES[c].hdr[95:88]) * PRG_PAGE;
      sum += longint'(CASES[c].hdr[87:80]) * CHR_PAGE;
    end
    return sum;
  endfunction

  // Slow memory that acks after 0 to 3 cycles and records each write
  initial begin : mem_responder
    int wait_cycles;
    mem_ack     = 1'b0;
    wait_cycles = 0;
    forever begin
      @(negedge clk);
      if (reset) begin
        mem_ack = 1'b0;
      end else if (mem_ack) begin
        if (!mem_req) begin   // Return to zero
          mem_ack     = 1'b0;
          wait_cycles = $urandom_range(3, 0);
        end
      end else if (mem_req) begin
        if (wait_cycles == 0) begin
          if (written.exists(mem_wr.addr)) dup_count++;
          written[mem_wr.addr] = mem_wr.data;
          write_count++;
          mem_ack = 1'b1;
        end else begin
          wait_cycles--;
        end
      end
    end
  end

  initial begin : watchdog
    longint limit_ns;
    limit_ns = total_bytes() * 16 * CLK_PERIOD + 1000 * CLK_PERIOD; // 16 cycles a byte
    #(limit_ns);
    $display("Simulation timed out after %0d ns, loader never finished", limit_ns);
    $display("*** FAILED ***");
    $finish;
  end

  initial begin
    reset       = 1'b1;
    in_valid    = 1'b0;
    in_byte     = '0;
    error_count = 0;
    pass_count  = 0;
    fail_count  = 0;
    void'($urandom(32'hb2b11ef6));
    for (int c = 0; c < NUM_CASES; c++) run_case(c);
    $display("%0d cases passed, %0d cases failed", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire
